// File: src/amp_ui_pkg.sv
// Shared types and constants for the amplifier front panel, imported by every RTL block
package amp_ui_pkg;

	// Number of effect buttons on the panel
	localparam int num_effects = 8;

	// Clock cycles per display refresh, 60 Hz from a 50 MHz clock
	localparam int default_frame_div = 833334;

	// Effect 0 to 7, shown as 1 to 8 on the panel
	typedef logic [2:0] effect_id_t;

	// Index into the fixed draw list
	typedef logic [3:0] draw_step_t;

	// Band that a tone step applies to
	typedef enum logic [1:0] {
		band_gain,
		band_treble,
		band_bass
	} tone_band_t;

	// Raw button levels from the panel
	typedef struct packed {
		logic [num_effects-1:0] go_effect;
		logic clear;
		logic gain_up;
		logic gain_down;
		logic treble_up;
		logic treble_down;
		logic bass_up;
		logic bass_down;
		logic record_yes;
		logic record_no;
		logic play_yes;
		logic play_no;
	} panel_buttons_t;

	// Command levels towards the amplifier core
	typedef struct packed {
		logic start_amp;
		logic idle;
		logic set_effect;
		effect_id_t effect;
		logic unset_effect;
		logic tone_step;
		tone_band_t tone_band;
		// 1 steps the band up
		logic tone_up;
		logic set_record;
		logic unset_record;
		logic set_play;
		logic unset_play;
	} panel_cmd_t;

endpackage

// File: src/panel_control.sv
// Moore FSM that turns panel button levels into effect, tone and session commands
module panel_control import amp_ui_pkg::*; (
	input  logic           clk,
	input  logic           resetn,
	input  panel_buttons_t buttons,
	output panel_cmd_t     cmd
);

	typedef enum logic [3:0] {
		st_start,
		st_idle,
		st_effect,
		st_clear,
		st_tone_hold,
		st_tone_step,
		st_record,
		st_record_end,
		st_play,
		st_play_end
	} panel_state_t;

	panel_state_t state_q;
	panel_state_t state_d;

	// Latched at the press, used while the press lasts
	effect_id_t effect_q;
	effect_id_t effect_d;
	tone_band_t band_q;
	tone_band_t band_d;
	logic       up_q;
	logic       up_d;

	// Lowest pressed effect wins
	function automatic effect_id_t lowest_effect(logic [num_effects-1:0] go);
		effect_id_t id;
		id = '0;
		for (int i = num_effects - 1; i >= 0; i--) begin
			if (go[i]) begin
				id = effect_id_t'(i);
			end
		end
		return id;
	endfunction

	// Level of the tone button that started the current hold
	function automatic logic tone_button(panel_buttons_t b, tone_band_t band, logic up);
		logic level;
		case (band)
			band_gain:   level = up ? b.gain_up : b.gain_down;
			band_treble: level = up ? b.treble_up : b.treble_down;
			default:     level = up ? b.bass_up : b.bass_down;
		endcase
		return level;
	endfunction

	always_comb begin
		state_d  = state_q;
		effect_d = effect_q;
		band_d   = band_q;
		up_d     = up_q;

		case (state_q)
			st_start: begin
				state_d = st_idle;
			end

			// Priority: effects, clear, tone buttons, then sessions
			st_idle: begin
				if (|buttons.go_effect) begin
					state_d  = st_effect;
					effect_d = lowest_effect(buttons.go_effect);
				end else if (buttons.clear) begin
					state_d = st_clear;
				end else if (buttons.gain_up) begin
					state_d = st_tone_hold;
					band_d  = band_gain;
					up_d    = 1'b1;
				end else if (buttons.gain_down) begin
					state_d = st_tone_hold;
					band_d  = band_gain;
					up_d    = 1'b0;
				end else if (buttons.treble_up) begin
					state_d = st_tone_hold;
					band_d  = band_treble;
					up_d    = 1'b1;
				end else if (buttons.treble_down) begin
					state_d = st_tone_hold;
					band_d  = band_treble;
					up_d    = 1'b0;
				end else if (buttons.bass_up) begin
					state_d = st_tone_hold;
					band_d  = band_bass;
					up_d    = 1'b1;
				end else if (buttons.bass_down) begin
					state_d = st_tone_hold;
					band_d  = band_bass;
					up_d    = 1'b0;
				end else if (buttons.record_yes) begin
					state_d = st_record;
				end else if (buttons.play_yes) begin
					state_d = st_play;
				end
			end

			st_effect: begin
				if (!buttons.go_effect[effect_q]) begin
					state_d = st_idle;
				end
			end

			st_clear: begin
				if (!buttons.clear) begin
					state_d = st_idle;
				end
			end

			// Step fires only once the button is let go
			st_tone_hold: begin
				if (!tone_button(buttons, band_q, up_q)) begin
					state_d = st_tone_step;
				end
			end

			st_tone_step: begin
				state_d = st_idle;
			end

			st_record: begin
				if (buttons.record_no) begin
					state_d = st_record_end;
				end
			end

			st_record_end: begin
				state_d = st_idle;
			end

			st_play: begin
				if (buttons.play_no) begin
					state_d = st_play_end;
				end
			end

			st_play_end: begin
				state_d = st_idle;
			end

			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= st_start;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clk) begin
		effect_q <= effect_d;
		band_q   <= band_d;
		up_q     <= up_d;
	end

	// Commands come from the state register only
	always_comb begin
		cmd = '0;
		case (state_q)
			st_start:      cmd.start_amp = 1'b1;
			st_idle:       cmd.idle = 1'b1;
			st_effect: begin
				cmd.set_effect = 1'b1;
				cmd.effect     = effect_q;
			end
			st_clear:      cmd.unset_effect = 1'b1;
			st_tone_step: begin
				cmd.tone_step = 1'b1;
				cmd.tone_band = band_q;
				cmd.tone_up   = up_q;
			end
			st_record:     cmd.set_record = 1'b1;
			st_record_end: cmd.unset_record = 1'b1;
			st_play:       cmd.set_play = 1'b1;
			st_play_end:   cmd.unset_play = 1'b1;
			default:       cmd = '0;
		endcase
	end

	// Never two commands to the core at once
	assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({cmd.set_effect, cmd.unset_effect, cmd.tone_step, cmd.set_record,
			cmd.unset_record, cmd.set_play, cmd.unset_play}));

	// One step per press
	assert property (@(posedge clk) disable iff (!resetn)
		cmd.tone_step |=> !cmd.tone_step);

endmodule

// File: src/frame_tick.sv
// Clock divider that gives the display sequencer a one-cycle refresh tick
module frame_tick import amp_ui_pkg::*; #(
	parameter int frame_div = default_frame_div
) (
	input  logic clk,
	input  logic resetn,
	output logic tick
);

	localparam int cnt_w = (frame_div > 1) ? $clog2(frame_div) : 1;

	logic [cnt_w-1:0] count_q;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count_q <= '0;
			tick    <= 1'b0;
		end else if (count_q == cnt_w'(frame_div - 1)) begin
			count_q <= '0;
			tick    <= 1'b1;
		end else begin
			count_q <= count_q + 1'b1;
			tick    <= 1'b0;
		end
	end

	// A real divider never gives back-to-back ticks
	if (frame_div > 1) begin : g_tick_check
		assert property (@(posedge clk) disable iff (!resetn)
			tick |=> !tick);
	end

endmodule

// File: src/display_sequencer.sv
// FSM that walks the sixteen draw steps per refresh with a request/done handshake
module display_sequencer import amp_ui_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       tick,
	input  logic       draw_done,
	output logic       draw_req,
	output draw_step_t draw_step,
	output logic       write_en
);

	typedef enum logic {
		st_idle,
		st_busy
	} seq_state_t;

	// Effect 8 is the last entry of the draw list
	localparam draw_step_t last_step = draw_step_t'(15);

	seq_state_t state_q;
	seq_state_t state_d;
	draw_step_t step_q;
	draw_step_t step_d;

	always_comb begin
		state_d = state_q;
		step_d  = step_q;

		case (state_q)
			// Ticks while busy are simply not looked at
			st_idle: begin
				if (tick) begin
					state_d = st_busy;
					step_d  = '0;
				end
			end

			st_busy: begin
				if (draw_done) begin
					// Counter wraps back to 0 after the last step
					step_d = step_q + 1'b1;
					if (step_q == last_step) begin
						state_d = st_idle;
					end
				end
			end

			default: begin
				state_d = st_idle;
				step_d  = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= st_idle;
			step_q  <= '0;
		end else begin
			state_q <= state_d;
			step_q  <= step_d;
		end
	end

	assign draw_req  = (state_q == st_busy);
	assign draw_step = step_q;

	// Pixel writes stay open for the whole refresh
	assign write_en = (state_q == st_busy);

	// Pixel engine sees a stable step until it answers
	assert property (@(posedge clk) disable iff (!resetn)
		(draw_req && !draw_done) |=> $stable(draw_step));

endmodule

// File: src/amp_ui_top.sv
// Top level of the front-panel controller, joining buttons, refresh tick and display steps
module amp_ui_top import amp_ui_pkg::*; #(
	parameter int frame_div = default_frame_div
) (
	input  logic           clk,
	input  logic           resetn,
	input  panel_buttons_t buttons,
	output panel_cmd_t     cmd,
	input  logic           draw_done,
	output logic           draw_req,
	output draw_step_t     draw_step,
	output logic           write_en
);

	// Refresh pulse from the divider
	logic tick;

	panel_control u_panel_control (
		.clk     (clk),
		.resetn  (resetn),
		.buttons (buttons),
		.cmd     (cmd)
	);

	frame_tick #(
		.frame_div (frame_div)
	) u_frame_tick (
		.clk    (clk),
		.resetn (resetn),
		.tick   (tick)
	);

	// Drives the pixel engine directly
	display_sequencer u_display_sequencer (
		.clk       (clk),
		.resetn    (resetn),
		.tick      (tick),
		.draw_done (draw_done),
		.draw_req  (draw_req),
		.draw_step (draw_step),
		.write_en  (write_en)
	);

endmodule

// File: testbench/tb_amp_ui.sv
// Random-stimulus testbench that checks the front-panel controller against a cycle model
module tb_amp_ui import amp_ui_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int frame_div    = 64;
	localparam int panel_cycles = 3000;
	localparam int btn_w        = $bits(panel_buttons_t);
	// Slowest refresh is 16 steps of 6 cycles, so six times the panel phase is ample
	localparam int timeout_cycles = panel_cycles * 6 + 2000;

	// Panel model states
	localparam int pm_start      = 0;
	localparam int pm_idle       = 1;
	localparam int pm_effect     = 2;
	localparam int pm_clear      = 3;
	localparam int pm_tone_hold  = 4;
	localparam int pm_tone_step  = 5;
	localparam int pm_record     = 6;
	localparam int pm_record_end = 7;
	localparam int pm_play       = 8;
	localparam int pm_play_end   = 9;

	logic           clk;
	logic           resetn;
	panel_buttons_t buttons;
	panel_cmd_t     cmd;
	logic           draw_done;
	logic           draw_req;
	draw_step_t     draw_step;
	logic           write_en;

	logic [15:0]    lfsr_state;
	panel_buttons_t pattern;
	int             hold_left;
	int             pm_state;
	int             pm_effect_num;
	tone_band_t     pm_band;
	logic           pm_up;
	int             frame_count;
	logic           tick_model;
	logic           seq_busy;
	int             seq_step;
	logic           slow_refresh;
	int             done_wait;
	int             refresh_count;
	int             dropped_ticks;
	int             tone_steps;
	int             sessions_ended;
	int             panel_errors;
	int             display_errors;
	int             other_errors;
	int             cycle_count;

	amp_ui_top #(
		.frame_div (frame_div)
	) u_dut (
		.clk       (clk),
		.resetn    (resetn),
		.buttons   (buttons),
		.cmd       (cmd),
		.draw_done (draw_done),
		.draw_req  (draw_req),
		.draw_step (draw_step),
		.write_en  (write_en)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Run stopped after %0d cycles without finishing", cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic int rand_bits(int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
		end
		return value;
	endfunction

	// Lowest set bit, or -1
	function automatic int first_set(logic [7:0] v);
		int idx;
		idx = -1;
		for (int i = 7; i >= 0; i--) begin
			if (v[i]) begin
				idx = i;
			end
		end
		return idx;
	endfunction

	// Tone buttons in priority order, bit 0 is gain up
	function automatic logic [5:0] tone_bits(panel_buttons_t b);
		return {b.bass_down, b.bass_up, b.treble_down, b.treble_up, b.gain_down, b.gain_up};
	endfunction

	function automatic panel_cmd_t expected_cmd();
		panel_cmd_t c;
		c = '0;
		case (pm_state)
			pm_start:      c.start_amp = 1'b1;
			pm_idle:       c.idle = 1'b1;
			pm_effect: begin
				c.set_effect = 1'b1;
				c.effect     = effect_id_t'(pm_effect_num);
			end
			pm_clear:      c.unset_effect = 1'b1;
			pm_tone_step: begin
				c.tone_step = 1'b1;
				c.tone_band = pm_band;
				c.tone_up   = pm_up;
			end
			pm_record:     c.set_record = 1'b1;
			pm_record_end: c.unset_record = 1'b1;
			pm_play:       c.set_play = 1'b1;
			pm_play_end:   c.unset_play = 1'b1;
			default:       c = '0;
		endcase
		return c;
	endfunction

	task automatic check_outputs();
		panel_cmd_t exp_cmd;
		string      name;
		exp_cmd = expected_cmd();
		name = (pm_state == pm_start) ? "reset" : "panel";
		if (cmd !== exp_cmd) begin
			panel_errors++;
			$display("ERROR %s: expected cmd %h, actual %h", name, exp_cmd, cmd);
		end
		if (draw_req !== seq_busy) begin
			display_errors++;
			$display("ERROR refresh: expected draw_req %b, actual %b", seq_busy, draw_req);
		end
		if (write_en !== seq_busy) begin
			display_errors++;
			$display("ERROR refresh: expected write_en %b, actual %b", seq_busy, write_en);
		end
		if (draw_step !== draw_step_t'(seq_step)) begin
			display_errors++;
			$display("ERROR refresh: expected draw_step %0d, actual %0d", seq_step, draw_step);
		end
	endtask

	// Mostly one button, now and then a random mix
	task automatic next_buttons();
		int kind;
		int pick;
		if (hold_left > 0) begin
			hold_left--;
		end else begin
			kind = rand_bits(3);
			pattern = '0;
			if (kind == 7) begin
				pattern = panel_buttons_t'(btn_w'(rand_bits(btn_w)));
			end else if (kind != 0) begin
				pick = rand_bits(5) % btn_w;
				pattern = panel_buttons_t'(btn_w'(1) << pick);
			end
			hold_left = rand_bits(3);
			buttons = pattern;
		end
	endtask

	// Pixel engine, every other refresh answers slowly so ticks land mid refresh
	task automatic drive_done();
		if (seq_busy) begin
			if (done_wait < 0) begin
				done_wait = slow_refresh ? 4 + rand_bits(1) : rand_bits(3) % 6;
			end
			if (done_wait == 0) begin
				draw_done = 1'b1;
				done_wait = -1;
			end else begin
				draw_done = 1'b0;
				done_wait--;
			end
		end else begin
			draw_done = rand_bits(1) != 0;
			done_wait = -1;
		end
	endtask

	task automatic step_panel(input panel_buttons_t b);
		int         eff;
		int         tone;
		logic [5:0] tones;
		tones = tone_bits(b);
		eff   = first_set(b.go_effect);
		tone  = first_set({2'b00, tones});
		case (pm_state)
			pm_start: pm_state = pm_idle;
			pm_idle: begin
				if (eff >= 0) begin
					pm_state      = pm_effect;
					pm_effect_num = eff;
				end else if (b.clear) begin
					pm_state = pm_clear;
				end else if (tone >= 0) begin
					pm_state = pm_tone_hold;
					pm_band  = tone_band_t'(tone / 2);
					pm_up    = (tone % 2) == 0;
				end else if (b.record_yes) begin
					pm_state = pm_record;
				end else if (b.play_yes) begin
					pm_state = pm_play;
				end
			end
			pm_effect: begin
				if (!b.go_effect[pm_effect_num]) begin
					pm_state = pm_idle;
				end
			end
			pm_clear: begin
				if (!b.clear) begin
					pm_state = pm_idle;
				end
			end
			pm_tone_hold: begin
				if (!tones[int'(pm_band) * 2 + (pm_up ? 0 : 1)]) begin
					pm_state = pm_tone_step;
					tone_steps++;
				end
			end
			pm_record: begin
				if (b.record_no) begin
					pm_state = pm_record_end;
					sessions_ended++;
				end
			end
			pm_play: begin
				if (b.play_no) begin
					pm_state = pm_play_end;
					sessions_ended++;
				end
			end
			default: pm_state = pm_idle;
		endcase
	endtask

	task automatic step_display(input logic done);
		logic busy_next;
		int   step_next;
		busy_next = seq_busy;
		step_next = seq_step;
		if (!seq_busy) begin
			if (tick_model) begin
				busy_next    = 1'b1;
				step_next    = 0;
				slow_refresh = !slow_refresh;
			end
		end else begin
			if (tick_model) begin
				dropped_ticks++;
			end
			if (done) begin
				step_next = (seq_step + 1) % 16;
				if (seq_step == 15) begin
					busy_next = 1'b0;
					refresh_count++;
				end
			end
		end
		seq_busy = busy_next;
		seq_step = step_next;
		tick_model = (frame_count == frame_div - 1);
		frame_count = tick_model ? 0 : frame_count + 1;
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		buttons = '0;
		draw_done = 1'b0;
		lfsr_state = 16'd87;
		cycle_count = 0;
		hold_left = 0;
		pattern = '0;
		pm_effect_num = 0;
		pm_band = band_gain;
		pm_up = 1'b0;
		slow_refresh = 1'b1;
		refresh_count = 0;
		dropped_ticks = 0;
		tone_steps = 0;
		sessions_ended = 0;
		panel_errors = 0;
		display_errors = 0;
		other_errors = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		// Registers still hold their reset values here
		pm_state = pm_start;
		frame_count = 0;
		tick_model = 1'b0;
		seq_busy = 1'b0;
		seq_step = 0;
		done_wait = -1;
		for (int cyc = 0; cyc < panel_cycles || seq_busy; cyc++) begin
			check_outputs();
			if (cyc < panel_cycles) begin
				next_buttons();
			end else begin
				buttons = '0;
			end
			drive_done();
			step_panel(buttons);
			step_display(draw_done);
			@(negedge clk);
		end
		check_outputs();
		if (tone_steps == 0 || sessions_ended == 0) begin
			other_errors++;
			$display("The random buttons never finished a tone step or a session");
		end
		if (refresh_count == 0 || dropped_ticks == 0) begin
			other_errors++;
			$display("No refresh completed or no tick landed during a refresh");
		end
		$display("Errors: panel %0d, refresh %0d, other %0d (refreshes %0d, dropped ticks %0d)",
			panel_errors, display_errors, other_errors, refresh_count, dropped_ticks);
		if (panel_errors + display_errors + other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: src.f
src/amp_ui_pkg.sv
src/panel_control.sv
src/frame_tick.sv
src/display_sequencer.sv
src/amp_ui_top.sv
testbench/tb_amp_ui.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_amp_ui
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from finding the pass line in the simulator output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
